//--- flist.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/reg_file.sv
verilog/inst_decode.sv
verilog/id_exe.sv
verilog/exe_unit.sv
verilog/core_top.sv
testbench/tb_core.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run, pass only if the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module tb_core -f flist.f &&
{ out=$(./obj_dir/Vtb_core); echo "$out"; } &&
echo "$out" | grep -qx "No errors" ||
{ echo "FAIL"; exit 1; }
echo "PASS"

//--- testbench/tb_core.sv
`timescale 1ns/1ps

module tb_core
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int reset_cycles    = 3;
    localparam int directed_cycles = 36;
    localparam int rand_cycles     = 300;
    localparam int drain_cycles    = 4;
    localparam int margin_cycles   = 40;
    localparam int total_cycles    = reset_cycles + directed_cycles + rand_cycles
                                     + drain_cycles + margin_cycles;

    logic  clk_50MHz = 1'b0;
    logic  rst;
    logic  pause;
    inst_t inst;
    logic  inst_valid;
    wb_t   result;

    logic [15:0] model_regs [8];
    wb_t         exp_q [$];
    wb_t         chk_exp;
    logic        chk_valid;
    int          errors;
    int          checked;
    string       test_name;

    always #10 clk_50MHz = ~clk_50MHz;

    core_top i_core_top (
        .clk_50MHz  (clk_50MHz),
        .rst        (rst),
        .pause      (pause),
        .inst       (inst),
        .inst_valid (inst_valid),
        .result     (result)
    );

    // result must match the oldest outstanding instruction
    assert property (@(posedge clk_50MHz) disable iff (!rst)
        (result.valid && chk_valid) |-> (result == chk_exp))
        else begin
            errors++;
            $display("** Error %s: expected r%0d=%h, actual r%0d=%h (valid %b)", test_name,
                     chk_exp.addr, chk_exp.data, $sampled(result.addr),
                     $sampled(result.data), $sampled(result.valid));
        end

    assert property (@(posedge clk_50MHz) disable iff (!rst)
        result.valid |-> chk_valid)
        else begin
            errors++;
            $display("%s: result valid while no instruction was outstanding", test_name);
        end

    function automatic inst_t make_r(funct_t f, reg_addr_t rx, reg_addr_t ry, reg_addr_t rz);
        inst_t v;
        v.r.opcode = op_rtype;
        v.r.rx     = rx;
        v.r.ry     = ry;
        v.r.rz     = rz;
        v.r.funct  = f;
        return v;
    endfunction

    function automatic inst_t make_i(opcode_t op, reg_addr_t rx, logic [7:0] imm);
        inst_t v;
        v.i.opcode = op;
        v.i.rx     = rx;
        v.i.imm8   = imm;
        return v;
    endfunction

    // small indices so that hazards come up often
    function automatic inst_t random_inst();
        inst_t v;
        case ($urandom_range(0, 5))
            0, 1: v = make_r(funct_t'(2'($urandom_range(0, 3))), 3'($urandom_range(0, 3)),
                             3'($urandom_range(0, 3)), 3'($urandom_range(0, 3)));
            2: v = make_i(op_addiu, 3'($urandom_range(0, 3)), 8'($urandom));
            3: v = make_i(op_li, 3'($urandom_range(0, 3)), 8'($urandom));
            4: v = make_i(op_nop, 3'($urandom_range(0, 3)), 8'($urandom));
            default: v = make_i(opcode_t'(5'b10110), 3'($urandom_range(0, 3)), 8'($urandom));
        endcase
        return v;
    endfunction

    // ISA semantics applied in program order
    task automatic predict(input inst_t v);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] y;
        reg_addr_t   dest;
        logic        writes;
        wb_t         e;
        a      = model_regs[v.r.rx];
        b      = model_regs[v.r.ry];
        y      = '0;
        dest   = v.i.rx;
        writes = 1'b1;
        case (v.r.opcode)
            op_rtype: begin
                dest = v.r.rz;
                case (v.r.funct)
                    addu:    y = a + b;
                    subu:    y = a - b;
                    and_op:  y = a & b;
                    default: y = a | b;
                endcase
            end
            op_addiu: y = a + {{8{v.i.imm8[7]}}, v.i.imm8};
            op_li:    y = {8'h00, v.i.imm8};
            default:  writes = 1'b0;
        endcase
        if (writes) begin
            model_regs[dest] = y;
            e.valid = 1'b1;
            e.addr  = dest;
            e.data  = y;
            exp_q.push_back(e);
        end
    endtask

    task automatic take_result();
        if (result.valid && exp_q.size() > 0) begin
            chk_exp   = exp_q.pop_front();
            chk_valid = 1'b1;
            checked++;
        end else begin
            chk_exp   = wb_bubble;
            chk_valid = 1'b0;
        end
    endtask

    // one cycle, inputs change on the falling edge
    task automatic step(input logic hold, input inst_t v, input logic v_valid);
        @(negedge clk_50MHz);
        take_result();
        pause = hold;
        if (!hold) begin
            inst       = v;
            inst_valid = v_valid;
            if (v_valid) begin
                predict(v);
            end
        end
    endtask

    task automatic send(input inst_t v);
        step(1'b0, v, 1'b1);
    endtask

    task automatic hold_cycle();
        step(1'b1, inst, inst_valid);
    endtask

    task automatic idle();
        step(1'b0, inst, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h228b));
        rst        = 1'b0;
        pause      = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        chk_exp    = wb_bubble;
        chk_valid  = 1'b0;
        errors     = 0;
        checked    = 0;
        test_name  = "reset_idle";
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk_50MHz);
        @(negedge clk_50MHz);
        rst = 1'b1;

        repeat (4) idle();

        test_name = "zero_regs";
        send(make_r(addu, 3'd1, 3'd2, 3'd3));
        send(make_r(subu, 3'd4, 3'd5, 3'd6));

        test_name = "r_format";
        send(make_i(op_li, 3'd1, 8'h35));
        send(make_i(op_addiu, 3'd2, 8'hff));
        send(make_i(op_addiu, 3'd2, 8'h80));
        send(make_r(addu, 3'd2, 3'd2, 3'd3));
        send(make_r(subu, 3'd1, 3'd2, 3'd4));
        send(make_r(and_op, 3'd2, 3'd1, 3'd5));
        send(make_r(or_op, 3'd1, 3'd4, 3'd6));

        // bit 7 set to tell sign from zero extension
        test_name = "imm_extend";
        send(make_i(op_li, 3'd5, 8'h80));
        send(make_i(op_addiu, 3'd6, 8'h80));
        send(make_i(op_li, 3'd7, 8'hff));
        send(make_i(op_addiu, 3'd7, 8'hff));

        test_name = "forwarding";
        send(make_i(op_addiu, 3'd1, 8'h01));
        send(make_i(op_addiu, 3'd1, 8'h01));
        send(make_r(addu, 3'd1, 3'd1, 3'd2));
        send(make_i(op_li, 3'd3, 8'h07));
        send(make_i(op_li, 3'd4, 8'h01));
        send(make_r(addu, 3'd3, 3'd4, 3'd5));
        send(make_r(subu, 3'd5, 3'd3, 3'd6));
        idle();
        send(make_r(or_op, 3'd6, 3'd5, 3'd7));

        test_name = "pause";
        send(make_i(op_li, 3'd2, 8'h09));
        hold_cycle();
        hold_cycle();
        send(make_r(addu, 3'd2, 3'd2, 3'd3));
        hold_cycle();
        send(make_r(subu, 3'd3, 3'd2, 3'd4));

        // r1 must keep its value through all three
        test_name = "no_result";
        send(make_i(op_nop, 3'd1, 8'hff));
        send(make_i(opcode_t'(5'b00000), 3'd1, 8'h55));
        step(1'b0, make_i(op_li, 3'd1, 8'haa), 1'b0);
        send(make_r(or_op, 3'd1, 3'd1, 3'd7));

        test_name = "random_stream";
        for (int n = 0; n < rand_cycles; n++) begin
            if ($urandom_range(0, 3) == 0) begin
                hold_cycle();
            end else begin
                step(1'b0, random_inst(), $urandom_range(0, 7) != 0);
            end
        end

        test_name = "drain";
        repeat (drain_cycles) idle();
        @(negedge clk_50MHz);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d instructions never produced a result", exp_q.size());
        end
        $display("checked %0d results, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(total_cycles * 20);
        errors++;
        $display("watchdog expired after %0d cycles, the run did not finish", total_cycles);
        $display("checked %0d results, %0d errors", checked, errors);
        $display("Errors found");
        $finish;
    end

endmodule

//--- verilog/core_top.sv
`timescale 1ns/1ps

module core_top
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic  clk_50MHz,
    input  logic  rst,
    input  logic  pause,
    input  inst_t inst,
    input  logic  inst_valid,
    output wb_t   result
);

    reg_addr_t   raddr_a;
    reg_addr_t   raddr_b;
    logic [15:0] rdata_a;
    logic [15:0] rdata_b;
    id_ex_t      id_next;
    id_ex_t      id_cur;
    wb_t         fwd;
    wb_t         wb;

    inst_decode i_inst_decode (
        .inst       (inst),
        .inst_valid (inst_valid),
        .raddr_a    (raddr_a),
        .raddr_b    (raddr_b),
        .rdata_a    (rdata_a),
        .rdata_b    (rdata_b),
        .fwd        (fwd),
        .id_next    (id_next)
    );

    reg_file i_reg_file (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .raddr_a   (raddr_a),
        .raddr_b   (raddr_b),
        .rdata_a   (rdata_a),
        .rdata_b   (rdata_b),
        .wr        (wb)
    );

    id_exe i_id_exe (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .pause     (pause),
        .id_next   (id_next),
        .id_cur    (id_cur)
    );

    exe_unit i_exe_unit (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .pause     (pause),
        .id_cur    (id_cur),
        .fwd       (fwd),
        .wb        (wb)
    );

    assign result = wb;

endmodule

//--- verilog/exe_unit.sv
`timescale 1ns/1ps

module exe_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic   clk_50MHz,
    input  logic   rst,
    input  logic   pause,
    input  id_ex_t id_cur,
    output wb_t    fwd,
    output wb_t    wb
);

    logic [data_w-1:0] alu_b;
    logic [data_w-1:0] alu_y;

    assign alu_b = id_cur.ctrl.b_is_imm ? id_cur.imm : id_cur.opb;

    // wraps at 16 bits
    always_comb begin
        case (id_cur.ctrl.alu_op)
            alu_add: alu_y = id_cur.opa + alu_b;
            alu_sub: alu_y = id_cur.opa - alu_b;
            alu_and: alu_y = id_cur.opa & alu_b;
            default: alu_y = id_cur.opa | alu_b;
        endcase
    end

    assign fwd.valid = id_cur.ctrl.valid;
    assign fwd.addr  = id_cur.ctrl.wb_addr;
    assign fwd.data  = alu_y;

    // held instruction retires only on the cycle pause drops
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            wb <= wb_bubble;
        end else if (pause) begin
            wb <= wb_bubble;
        end else begin
            wb <= fwd;
        end
    end

    // no double retire while id_exe holds
    assert property (@(posedge clk_50MHz) disable iff (!rst)
        pause |=> !wb.valid)
        else $error("write-back valid after a paused cycle");

    assert property (@(posedge clk_50MHz) disable iff (!rst)
        wb.valid |-> !$isunknown(wb))
        else $error("write-back carries unknown bits");

endmodule

//--- verilog/id_exe.sv
`timescale 1ns/1ps

module id_exe
    import pipe_pkg::*;
(
    input  logic   clk_50MHz,
    input  logic   rst,
    input  logic   pause,
    input  id_ex_t id_next,
    output id_ex_t id_cur
);

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            id_cur <= id_bubble;
        end else if (!pause) begin
            id_cur <= id_next;
        end
    end

    // a stalled instruction must not change while it waits
    assert property (@(posedge clk_50MHz) disable iff (!rst)
        pause |=> $stable(id_cur))
        else $error("id_exe changed during pause");

endmodule

//--- verilog/inst_decode.sv
`timescale 1ns/1ps

module inst_decode
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  inst_t       inst,
    input  logic        inst_valid,
    output reg_addr_t   raddr_a,
    output reg_addr_t   raddr_b,
    input  logic [15:0] rdata_a,
    input  logic [15:0] rdata_b,
    input  wb_t         fwd,
    output id_ex_t      id_next
);

    logic [data_w-1:0] op_a;
    logic [data_w-1:0] op_b;
    logic [data_w-1:0] imm_sext;
    logic [data_w-1:0] imm_zext;

    // rx and ry sit at the same bits in both formats
    assign raddr_a = inst.r.rx;
    assign raddr_b = inst.r.ry;

    // result still in execute wins over the file
    assign op_a = (fwd.valid && fwd.addr == raddr_a) ? fwd.data : rdata_a;
    assign op_b = (fwd.valid && fwd.addr == raddr_b) ? fwd.data : rdata_b;

    assign imm_sext = {{(data_w - 8){inst.i.imm8[7]}}, inst.i.imm8};
    assign imm_zext = {{(data_w - 8){1'b0}}, inst.i.imm8};

    always_comb begin
        id_next               = id_bubble;
        id_next.opa           = op_a;
        id_next.opb           = op_b;
        id_next.ctrl.wb_addr  = inst.r.rx;

        case (inst.r.opcode)
            op_rtype: begin
                id_next.ctrl.valid   = inst_valid;
                id_next.ctrl.wb_addr = inst.r.rz;
                case (inst.r.funct)
                    addu:    id_next.ctrl.alu_op = alu_add;
                    subu:    id_next.ctrl.alu_op = alu_sub;
                    and_op:  id_next.ctrl.alu_op = alu_and;
                    default: id_next.ctrl.alu_op = alu_or;
                endcase
            end
            op_addiu: begin
                id_next.ctrl.valid    = inst_valid;
                id_next.ctrl.alu_op   = alu_add;
                id_next.ctrl.b_is_imm = 1'b1;
                id_next.imm           = imm_sext;
            end
            op_li: begin
                // zero plus the immediate
                id_next.ctrl.valid    = inst_valid;
                id_next.ctrl.alu_op   = alu_add;
                id_next.ctrl.b_is_imm = 1'b1;
                id_next.opa           = '0;
                id_next.imm           = imm_zext;
            end
            default: begin
                // nop and unknown codes
                id_next.ctrl.valid = 1'b0;
            end
        endcase
    end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic        clk_50MHz,
    input  logic        rst,
    input  reg_addr_t   raddr_a,
    input  reg_addr_t   raddr_b,
    output logic [15:0] rdata_a,
    output logic [15:0] rdata_b,
    input  wb_t         wr
);

    logic [data_w-1:0] regs [8];

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // decode sees a write in the same cycle
    always_comb begin
        if (wr.valid && wr.addr == raddr_a) begin
            rdata_a = wr.data;
        end else begin
            rdata_a = regs[raddr_a];
        end
        if (wr.valid && wr.addr == raddr_b) begin
            rdata_b = wr.data;
        end else begin
            rdata_b = regs[raddr_b];
        end
    end

endmodule

//--- verilog/pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    typedef enum logic [1:0] {
        alu_add = 2'b00,
        alu_sub = 2'b01,
        alu_and = 2'b10,
        alu_or  = 2'b11
    } alu_op_t;

    // decoded control fields
    typedef struct packed {
        logic      valid;
        alu_op_t   alu_op;
        logic      b_is_imm;
        reg_addr_t wb_addr;
    } ctrl_t;

    // decode to execute bundle
    typedef struct packed {
        ctrl_t             ctrl;
        logic [data_w-1:0] opa;
        logic [data_w-1:0] opb;
        logic [data_w-1:0] imm;
    } id_ex_t;

    // write-back, forwarding and result
    typedef struct packed {
        logic              valid;
        reg_addr_t         addr;
        logic [data_w-1:0] data;
    } wb_t;

    // empty slots
    localparam id_ex_t id_bubble = '0;
    localparam wb_t    wb_bubble = '0;

endpackage

//--- verilog/isa_pkg.sv
package isa_pkg;

    // machine word
    localparam int data_w = 16;

    typedef logic [2:0] reg_addr_t;

    // anything outside these major opcodes decodes as a nop
    typedef enum logic [4:0] {
        op_nop   = 5'b00001,
        op_addiu = 5'b01001,
        op_li    = 5'b01101,
        op_rtype = 5'b11100
    } opcode_t;

    // low bits of an R-format word
    typedef enum logic [1:0] {
        addu   = 2'b00,
        subu   = 2'b01,
        and_op = 2'b10,
        or_op  = 2'b11
    } funct_t;

    // rz <- rx op ry
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rx;
        reg_addr_t ry;
        reg_addr_t rz;
        funct_t    funct;
    } r_format_t;

    // rx <- rx + imm8 or imm8 alone
    typedef struct packed {
        opcode_t    opcode;
        reg_addr_t  rx;
        logic [7:0] imm8;
    } i_format_t;

    // opcode sits in bits 15..11 for both views
    typedef union packed {
        r_format_t r;
        i_format_t i;
    } inst_t;

endpackage
